// File: logic/vga_pkg.sv
package vga_pkg;

  // --------------------
  // pixel word
  // --------------------
  typedef struct packed {
    logic [4:0] r;   // msbs of the word
    logic [5:0] g;
    logic [4:0] b;   // lsbs
  } rgb565_t;

  // generators write raw codes, output stage reads fields
  typedef union packed {
    logic [15:0] raw;
    rgb565_t     rgb;
  } pixel_u;

  // --------------------
  // scan position and sync
  // --------------------
  typedef struct packed {
    logic [10:0] ax;   // active column, 0 outside window
    logic [9:0]  ay;   // active row, 0 outside window
  } scan_pos_t;

  typedef struct packed {
    logic hs;   // active low
    logic vs;   // active low
    logic de;   // high in display window
  } sync_t;

  // --------------------
  // display modes
  // --------------------
  typedef enum logic [3:0] {
    MODE_BLACK, MODE_WHITE, MODE_RED, MODE_GREEN, MODE_BLUE,
    MODE_GRID_S, MODE_GRID_L,
    MODE_GREY_H, MODE_GREY_V,
    MODE_RED_H, MODE_GREEN_H, MODE_BLUE_H,
    MODE_BARS, MODE_RAINBOW
  } dis_mode_t;

  localparam dis_mode_t MODE_LAST = MODE_RAINBOW;   // counter wraps here

  // bar colours, in bar order
  localparam logic [15:0] COL_RED    = 16'hf800;
  localparam logic [15:0] COL_GREEN  = 16'h07e0;
  localparam logic [15:0] COL_BLUE   = 16'h001f;
  localparam logic [15:0] COL_PURPLE = 16'hf81f;
  localparam logic [15:0] COL_YELLOW = 16'hffe0;
  localparam logic [15:0] COL_CYAN   = 16'h07ff;
  localparam logic [15:0] COL_WHITE  = 16'hffff;
  localparam logic [15:0] COL_ORANGE = 16'hfc00;
  localparam logic [15:0] COL_BLACK  = 16'h0000;

endpackage

// File: logic/vga_timing.sv
`timescale 1ns/1ns

module vga_timing #(
  parameter int H_SYNC   = 136,
  parameter int H_BACK   = 160,
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int V_SYNC   = 6,
  parameter int V_BACK   = 29,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3
) (
  input  logic                vga_clk,
  input  logic                rstn,
  output vga_pkg::sync_t      sync,
  output vga_pkg::scan_pos_t  pos,
  output logic                frame_start   // one cycle at position 0,0
);

  localparam int H_TOTAL = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;
  localparam int V_TOTAL = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;
  localparam int H_START = H_SYNC + H_BACK;   // first active column
  localparam int V_START = V_SYNC + V_BACK;   // first active line
  localparam int HW      = $clog2(H_TOTAL);
  localparam int VW      = $clog2(V_TOTAL);

  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          h_last;
  logic          v_last;
  logic          in_win;

  assign h_last = (h_cnt == HW'(H_TOTAL - 1));
  assign v_last = (v_cnt == VW'(V_TOTAL - 1));
  assign in_win = (int'(h_cnt) >= H_START) && (int'(h_cnt) < H_START + H_ACTIVE) &&
                  (int'(v_cnt) >= V_START) && (int'(v_cnt) < V_START + V_ACTIVE);

  // --------------------
  // scan counters
  // --------------------
  always_ff @(posedge vga_clk) begin
    if (!rstn) begin
      h_cnt <= HW'(H_TOTAL - 1);   // parked on last pixel, so first edge lands on 0,0
      v_cnt <= VW'(V_TOTAL - 1);
    end else begin
      h_cnt <= h_last ? '0 : h_cnt + 1'b1;
      if (h_last) begin
        v_cnt <= v_last ? '0 : v_cnt + 1'b1;   // next line
      end
    end
  end

  // sync, window and coords, all one cycle behind the counts
  always_ff @(posedge vga_clk) begin
    if (!rstn) begin
      sync        <= '{hs: 1'b1, vs: 1'b1, de: 1'b0};
      pos         <= '0;
      frame_start <= 1'b0;
    end else begin
      sync.hs     <= !(int'(h_cnt) < H_SYNC);
      sync.vs     <= !(int'(v_cnt) < V_SYNC);
      sync.de     <= in_win;
      pos.ax      <= in_win ? 11'(h_cnt - HW'(H_START)) : '0;
      pos.ay      <= in_win ? 10'(v_cnt - VW'(V_START)) : '0;
      frame_start <= (h_cnt == '0) && (v_cnt == '0);
    end
  end

endmodule

// File: logic/key_mode_ctrl.sv
`timescale 1ns/1ns

module key_mode_ctrl #(
  parameter int KEY_HOLD = 90000   // low cycles for a valid press
) (
  input  logic                vga_clk,
  input  logic                rstn,
  input  logic                key1,   // active low
  output vga_pkg::dis_mode_t  mode
);

  localparam int CW = $clog2(KEY_HOLD + 1);

  logic [CW-1:0] low_cnt;   // consecutive low cycles, saturating
  logic          step;

  // hit only once per press, the count runs past it and stops
  assign step = (low_cnt == CW'(KEY_HOLD - 1));

  // --------------------
  // debounce counter
  // --------------------
  always_ff @(posedge vga_clk) begin
    if (!rstn) begin
      low_cnt <= '0;
    end else if (key1) begin
      low_cnt <= '0;                    // released, start over
    end else if (low_cnt != CW'(KEY_HOLD)) begin
      low_cnt <= low_cnt + 1'b1;
    end
  end

  // mode register, 0..13 then back to black
  always_ff @(posedge vga_clk) begin
    if (!rstn) begin
      mode <= vga_pkg::MODE_BLACK;
    end else if (step) begin
      mode <= (mode == vga_pkg::MODE_LAST) ? vga_pkg::MODE_BLACK
                                           : vga_pkg::dis_mode_t'(mode + 4'd1);
    end
  end

endmodule

// File: logic/rainbow_gen.sv
`timescale 1ns/1ns

module rainbow_gen (
  input  logic               vga_clk,
  input  logic               rstn,
  input  vga_pkg::sync_t     sync,
  input  logic               frame_start,
  output vga_pkg::pixel_u    rainbow
);

  logic [4:0]  frame_cnt;   // drifts the pattern one step per frame
  logic [9:0]  row_cnt;     // index of the next active row to start
  logic        de_d;
  logic        line_start;
  logic [15:0] word_new;
  logic [15:0] word_q;      // colour of the row in progress

  assign line_start = sync.de && !de_d;   // first de cycle of a line
  assign word_new   = 16'(frame_cnt) + 16'(row_cnt);

  // --------------------
  // frame and row counters
  // --------------------
  always_ff @(posedge vga_clk) begin
    if (!rstn) begin
      frame_cnt <= '0;
      row_cnt   <= '0;
      de_d      <= 1'b0;
    end else begin
      de_d <= sync.de;
      if (frame_start) begin
        frame_cnt <= frame_cnt + 1'b1;
        row_cnt   <= '0;                 // new frame starts at top row
      end else if (line_start) begin
        row_cnt <= row_cnt + 1'b1;
      end
    end
  end

  // hold the row colour for the rest of the line
  always_ff @(posedge vga_clk) begin
    if (line_start) begin
      word_q <= word_new;
    end
  end

  // bypass on the start cycle so the word is valid right away
  assign rainbow.raw = line_start ? word_new : word_q;

endmodule

// File: logic/pattern_gen.sv
`timescale 1ns/1ns

module pattern_gen #(
  parameter int H_ACTIVE = 1024
) (
  input  logic                vga_clk,
  input  logic                rstn,
  input  vga_pkg::dis_mode_t  mode,
  input  vga_pkg::sync_t      sync,
  input  vga_pkg::scan_pos_t  pos,
  input  vga_pkg::pixel_u     rainbow,
  output logic                vga_hs,
  output logic                vga_vs,
  output logic [4:0]          vga_r,
  output logic [5:0]          vga_g,
  output logic [4:0]          vga_b
);

  localparam int BAR_W = H_ACTIVE / 8;   // eight bars across the line

  vga_pkg::pixel_u pix;       // colour for this position
  logic [10:0]     bar_idx;   // bar under the current column
  logic [15:0]     bar_col;

  assign bar_idx = 11'(pos.ax / BAR_W);

  // --------------------
  // colour bars
  // --------------------
  always_comb begin
    case (bar_idx)
      11'd0:   bar_col = vga_pkg::COL_RED;
      11'd1:   bar_col = vga_pkg::COL_GREEN;
      11'd2:   bar_col = vga_pkg::COL_BLUE;
      11'd3:   bar_col = vga_pkg::COL_PURPLE;
      11'd4:   bar_col = vga_pkg::COL_YELLOW;
      11'd5:   bar_col = vga_pkg::COL_CYAN;
      11'd6:   bar_col = vga_pkg::COL_WHITE;
      11'd7:   bar_col = vga_pkg::COL_ORANGE;
      default: bar_col = vga_pkg::COL_BLACK;   // leftover columns
    endcase
  end

  // --------------------
  // pattern select
  // --------------------
  always_comb begin
    pix.raw = vga_pkg::COL_BLACK;   // fields not set below stay zero
    case (mode)
      vga_pkg::MODE_BLACK:   pix.raw = vga_pkg::COL_BLACK;
      vga_pkg::MODE_WHITE:   pix.raw = vga_pkg::COL_WHITE;
      vga_pkg::MODE_RED:     pix.rgb.r = '1;   // full scale
      vga_pkg::MODE_GREEN:   pix.rgb.g = '1;
      vga_pkg::MODE_BLUE:    pix.rgb.b = '1;
      vga_pkg::MODE_GRID_S: begin
        pix.raw = (pos.ax[4] == pos.ay[4]) ? vga_pkg::COL_WHITE : vga_pkg::COL_BLACK;
      end
      vga_pkg::MODE_GRID_L: begin
        pix.raw = (pos.ax[6] == pos.ay[6]) ? vga_pkg::COL_WHITE : vga_pkg::COL_BLACK;
      end
      vga_pkg::MODE_GREY_H: begin    // ramp along the line
        pix.rgb.r = pos.ax[6:2];
        pix.rgb.g = pos.ax[6:1];
        pix.rgb.b = pos.ax[6:2];
      end
      vga_pkg::MODE_GREY_V: begin    // ramp down the screen
        pix.rgb.r = pos.ay[6:2];
        pix.rgb.g = pos.ay[6:1];
        pix.rgb.b = pos.ay[6:2];
      end
      vga_pkg::MODE_RED_H:   pix.rgb.r = pos.ax[6:2];
      vga_pkg::MODE_GREEN_H: pix.rgb.g = pos.ax[6:1];
      vga_pkg::MODE_BLUE_H:  pix.rgb.b = pos.ax[6:2];
      vga_pkg::MODE_BARS:    pix.raw = bar_col;
      vga_pkg::MODE_RAINBOW: pix = rainbow;
      default:               pix.raw = vga_pkg::COL_WHITE;   // 14, 15 unreachable
    endcase
    if (!sync.de) begin
      pix.raw = vga_pkg::COL_BLACK;   // blank outside window
    end
  end

  // --------------------
  // output registers
  // --------------------
  always_ff @(posedge vga_clk) begin
    if (!rstn) begin
      vga_hs <= 1'b1;   // sync idle high
      vga_vs <= 1'b1;
      vga_r  <= '0;
      vga_g  <= '0;
      vga_b  <= '0;
    end else begin
      vga_hs <= sync.hs;
      vga_vs <= sync.vs;
      vga_r  <= pix.rgb.r;
      vga_g  <= pix.rgb.g;
      vga_b  <= pix.rgb.b;
    end
  end

endmodule

// File: logic/vga_pattern_top.sv
`timescale 1ns/1ns

module vga_pattern_top #(
  // 1024x768 at 60 Hz by default
  parameter int H_SYNC   = 136,
  parameter int H_BACK   = 160,
  parameter int H_ACTIVE = 1024,
  parameter int H_FRONT  = 24,
  parameter int V_SYNC   = 6,
  parameter int V_BACK   = 29,
  parameter int V_ACTIVE = 768,
  parameter int V_FRONT  = 3,
  parameter int KEY_HOLD = 90000
) (
  input  logic       vga_clk,
  input  logic       rstn,
  input  logic       key1,    // mode step key, active low
  output logic       vga_hs,
  output logic       vga_vs,
  output logic [4:0] vga_r,
  output logic [5:0] vga_g,
  output logic [4:0] vga_b
);

  vga_pkg::sync_t     sync;
  vga_pkg::scan_pos_t pos;
  logic               frame_start;
  vga_pkg::dis_mode_t mode;
  vga_pkg::pixel_u    rainbow;

  // --------------------
  // scan timing
  // --------------------
  vga_timing #(
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT)
  ) vga_timing_inst (
    .vga_clk     (vga_clk),
    .rstn        (rstn),
    .sync        (sync),
    .pos         (pos),
    .frame_start (frame_start)
  );

  key_mode_ctrl #(.KEY_HOLD(KEY_HOLD)) key_mode_ctrl_inst (
    .vga_clk (vga_clk),
    .rstn    (rstn),
    .key1    (key1),
    .mode    (mode)
  );

  rainbow_gen rainbow_gen_inst (
    .vga_clk     (vga_clk),
    .rstn        (rstn),
    .sync        (sync),
    .frame_start (frame_start),
    .rainbow     (rainbow)
  );

  // pattern mux and pin registers
  pattern_gen #(.H_ACTIVE(H_ACTIVE)) pattern_gen_inst (
    .vga_clk (vga_clk),
    .rstn    (rstn),
    .mode    (mode),
    .sync    (sync),
    .pos     (pos),
    .rainbow (rainbow),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b)
  );

endmodule

// File: testbench/tb_vga_pattern.sv
`timescale 1ns/1ns

module tb_vga_pattern;

  // small timing so a frame is only a few thousand cycles
  localparam int H_SYNC   = 8;
  localparam int H_BACK   = 8;
  localparam int H_ACTIVE = 128;
  localparam int H_FRONT  = 8;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 2;
  localparam int V_ACTIVE = 80;
  localparam int V_FRONT  = 2;
  localparam int KEY_HOLD = 8;

  localparam int LINE     = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;   // 152
  localparam int V_TOT    = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;   // 86
  localparam int FRAME    = LINE * V_TOT;                           // 13072
  localparam int PRESS_AT = (V_TOT - 1) * LINE;   // last blank line, counter position
  localparam int TIMEOUT  = 23 * FRAME;           // about 23 frames, test needs 19

  // expected pin values
  typedef struct packed {
    logic       hs;
    logic       vs;
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } pins_t;

  logic       vga_clk;
  logic       rstn;
  logic       key1;
  logic       vga_hs;
  logic       vga_vs;
  logic [4:0] vga_r;
  logic [5:0] vga_g;
  logic [4:0] vga_b;

  int     cyc = 0;          // rising edges since reset release
  int     run_cyc = 0;      // timeout counter
  int     model_mode = 0;
  integer seed;

  vga_pattern_top #(
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .KEY_HOLD (KEY_HOLD)
  ) vga_pattern_top_inst (
    .vga_clk (vga_clk),
    .rstn    (rstn),
    .key1    (key1),
    .vga_hs  (vga_hs),
    .vga_vs  (vga_vs),
    .vga_r   (vga_r),
    .vga_g   (vga_g),
    .vga_b   (vga_b)
  );

  initial begin
    vga_clk = 1'b0;
    forever #50 vga_clk = ~vga_clk;   // 100 ns period
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped on first failure");
  endtask

  // --------------------
  // reference model
  // --------------------
  function automatic pins_t ref_pins(input int idx, input int md, input int fcnt);
    pins_t       e;
    int          h;
    int          v;
    int          ax;
    int          ay;
    logic        de;
    logic [4:0]  rr;
    logic [5:0]  gg;
    logic [15:0] w;
    e = '0;
    e.hs = 1'b1;
    e.vs = 1'b1;
    if (idx < 0) begin
      return e;   // pipeline still holds reset values
    end
    h  = idx % LINE;
    v  = (idx / LINE) % V_TOT;
    de = (h >= H_SYNC + H_BACK) && (h < H_SYNC + H_BACK + H_ACTIVE) &&
         (v >= V_SYNC + V_BACK) && (v < V_SYNC + V_BACK + V_ACTIVE);
    ax = de ? h - (H_SYNC + H_BACK) : 0;
    ay = de ? v - (V_SYNC + V_BACK) : 0;
    e.hs = (h >= H_SYNC);   // low during sync pulse
    e.vs = (v >= V_SYNC);
    rr = 5'(((md == 8) ? ay : ax) >> 2);   // bits 6:2
    gg = 6'(((md == 8) ? ay : ax) >> 1);   // bits 6:1
    case (md)
      0:       w = 16'h0000;
      1:       w = 16'hffff;
      2:       w = 16'hf800;
      3:       w = 16'h07e0;
      4:       w = 16'h001f;
      5:       w = (((ax >> 4) & 1) == ((ay >> 4) & 1)) ? 16'hffff : 16'h0000;
      6:       w = (((ax >> 6) & 1) == ((ay >> 6) & 1)) ? 16'hffff : 16'h0000;
      7, 8:    w = {rr, gg, rr};   // grey ramps
      9:       w = {rr, 6'd0, 5'd0};
      10:      w = {5'd0, gg, 5'd0};
      11:      w = {5'd0, 6'd0, rr};
      12: begin
        case (ax / (H_ACTIVE / 8))
          0:       w = 16'hf800;
          1:       w = 16'h07e0;
          2:       w = 16'h001f;
          3:       w = 16'hf81f;
          4:       w = 16'hffe0;
          5:       w = 16'h07ff;
          6:       w = 16'hffff;
          7:       w = 16'hfc00;
          default: w = 16'h0000;
        endcase
      end
      13:      w = 16'(fcnt + ay);   // frame count plus row
      default: w = 16'hffff;
    endcase
    if (!de) begin
      w = 16'h0000;
    end
    e.r = w[15:11];
    e.g = w[10:5];
    e.b = w[4:0];
    return e;
  endfunction

  task automatic check_val(input string name, input logic [15:0] exp_v,
                           input logic [15:0] act_v);
    assert (act_v === exp_v) else begin
      $display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      abort_run("pin value differs from reference");
    end
  endtask

  // --------------------
  // per-cycle compare
  // --------------------
  always @(posedge vga_clk) begin : compare
    pins_t exp_p;
    int    idx;
    int    fcnt;
    if (rstn) begin
      idx   = cyc - 3;                        // pins lag the counters, read pre-edge
      fcnt  = (idx < 0) ? 0 : ((idx / FRAME) + 1) % 32;   // bumped at each frame start
      exp_p = ref_pins(idx, model_mode, fcnt);
      check_val("vga_hs", 16'(exp_p.hs), 16'(vga_hs));
      check_val("vga_vs", 16'(exp_p.vs), 16'(vga_vs));
      check_val("vga_r", 16'(exp_p.r), 16'(vga_r));
      check_val("vga_g", 16'(exp_p.g), 16'(vga_g));
      check_val("vga_b", 16'(exp_p.b), 16'(vga_b));
      cyc = cyc + 1;
    end
  end

  always @(posedge vga_clk) begin
    run_cyc = run_cyc + 1;
    if (run_cyc > TIMEOUT) begin
      abort_run("timeout, the test did not finish within the cycle limit");
    end
  end

  // --------------------
  // key stimulus
  // --------------------
  // counters hold position cyc-1 at a falling edge
  task automatic wait_slot();
    @(negedge vga_clk);
    while ((cyc - 1) % FRAME != PRESS_AT) begin
      @(negedge vga_clk);
    end
  endtask

  task automatic press_key(input int len);
    wait_slot();   // vertical blanking
    key1 = 1'b0;
    repeat (len) @(negedge vga_clk);
    key1 = 1'b1;
    repeat (20) @(negedge vga_clk);
    if (len >= KEY_HOLD - 1) begin
      model_mode = (model_mode == 13) ? 0 : model_mode + 1;
    end
  endtask

  initial begin
    seed = 99;
    rstn = 1'b0;
    key1 = 1'b1;
    repeat (4) @(posedge vga_clk);
    @(negedge vga_clk);
    rstn = 1'b1;
    // frame 0 black, then modes 1..13 one frame each
    repeat (13) press_key(KEY_HOLD + ($random(seed) & 15));
    wait_slot();   // rainbow held for three frames
    wait_slot();
    press_key(KEY_HOLD + ($random(seed) & 15));   // 13 wraps to 0
    press_key(KEY_HOLD - 2);                      // too short, no step
    press_key(40);                                // long, single step
    wait_slot();
    repeat (LINE + 4) @(negedge vga_clk);         // finish last frame through pipeline
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: compile.f
logic/vga_pkg.sv
logic/vga_timing.sv
logic/key_mode_ctrl.sv
logic/rainbow_gen.sv
logic/pattern_gen.sv
logic/vga_pattern_top.sv
testbench/tb_vga_pattern.sv
